//--- hw/ps2_params.svh
`ifndef PS2_PARAMS_SVH
`define PS2_PARAMS_SVH

// frame layout
`define PS2_DATA_W      8
`define PS2_FRAME_BITS  11   // start, data, parity, stop

// host request-to-send hold, in system clocks
`define PS2_RTS_CYCLES  400

// input synchronizer depth
`define PS2_SYNC_STAGES 2

`endif

//--- hw/ps2_pkg.sv
`include "ps2_params.svh"

package ps2_pkg;

    typedef logic [`PS2_DATA_W-1:0] ps2_byte_t;

    // whole frame as it appears on the wire, lsb is the start bit
    typedef logic [`PS2_FRAME_BITS-1:0] ps2_frame_t;

    // counts clock falls within one frame
    typedef logic [$clog2(`PS2_FRAME_BITS + 1)-1:0] ps2_bit_cnt_t;

    typedef logic [`PS2_SYNC_STAGES-1:0] ps2_sync_t;

    // ==============================
    // status register as seen by the cpu
    typedef struct packed {
        logic [4:0] reserved;   // reads as zero
        logic       ack_ok;     // device acked the last send
        logic       parity_ok;  // last frame had odd parity
        logic       has_data;   // byte waiting to be read
    } ps2_status_t;

endpackage

//--- hw/ps2_line_if.sv
`timescale 1ns/1ps

interface ps2_line_if;

    logic clk_fall;      // one-cycle strobe per falling edge
    logic data_level;    // synchronized data line
    logic rx_hold_clk;   // receiver wants the clock inhibited
    logic tx_active;     // send in progress
    logic tx_clk_low;    // request-to-send phase
    logic tx_data_low;   // current tx bit is 0

    modport sync (
        output clk_fall, data_level,
        input  rx_hold_clk, tx_active, tx_clk_low, tx_data_low
    );

    modport rx (
        input  clk_fall, data_level, tx_active,
        output rx_hold_clk
    );

    modport tx (
        input  clk_fall, data_level,
        output tx_active, tx_clk_low, tx_data_low
    );

endinterface

//--- hw/ps2_line_sync.sv
`timescale 1ns/1ps
`include "ps2_params.svh"

module ps2_line_sync
    import ps2_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       ps2_clk_in,
    input  logic       ps2_data_in,
    output logic       ps2_clk_drive_low,
    output logic       ps2_data_drive_low,
    ps2_line_if.sync   line
);

    ps2_sync_t clk_sync;
    ps2_sync_t data_sync;
    logic      clk_prev;

    // ==============================
    // input synchronizers and fall detect
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            clk_sync        <= '1;  // lines idle high
            data_sync       <= '1;
            clk_prev        <= 1'b1;
            line.clk_fall   <= 1'b0;
            line.data_level <= 1'b1;
        end else begin
            clk_sync        <= {clk_sync[`PS2_SYNC_STAGES-2:0], ps2_clk_in};
            data_sync       <= {data_sync[`PS2_SYNC_STAGES-2:0], ps2_data_in};
            clk_prev        <= clk_sync[`PS2_SYNC_STAGES-1];
            line.clk_fall   <= clk_prev & ~clk_sync[`PS2_SYNC_STAGES-1];
            line.data_level <= data_sync[`PS2_SYNC_STAGES-1];  // aligned with clk_fall
        end
    end

    // ==============================
    // open-drain drivers, registered so they never glitch
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ps2_clk_drive_low  <= 1'b0;
            ps2_data_drive_low <= 1'b0;
        end else begin
            // a send overrides the receive inhibit
            ps2_clk_drive_low  <= line.tx_clk_low | (line.rx_hold_clk & ~line.tx_active);
            ps2_data_drive_low <= line.tx_data_low;
        end
    end

endmodule

//--- hw/ps2_receiver.sv
`timescale 1ns/1ps
`include "ps2_params.svh"

module ps2_receiver
    import ps2_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      status_clear,
    output ps2_byte_t rx_byte,
    output logic      has_data,
    output logic      parity_ok,
    output logic      rx_busy,
    ps2_line_if.rx    line
);

    localparam ps2_bit_cnt_t LAST_BIT = ps2_bit_cnt_t'(`PS2_FRAME_BITS - 1);

    ps2_frame_t   frame;
    ps2_frame_t   frame_next;
    ps2_bit_cnt_t bit_cnt;
    logic         shift_en;
    logic         frame_done;

    // no shifting while a byte is pending, the clock is held then anyway
    assign shift_en   = line.clk_fall & ~has_data;
    assign frame_next = {line.data_level, frame[`PS2_FRAME_BITS-1:1]};  // lsb first
    assign frame_done = shift_en & ~line.tx_active & (bit_cnt == LAST_BIT);

    always_ff @(posedge clk) begin
        if (shift_en) begin
            frame <= frame_next;
        end
    end

    // ==============================
    // bit counter and status
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bit_cnt   <= '0;
            has_data  <= 1'b0;
            parity_ok <= 1'b0;
            rx_byte   <= '0;
        end else begin
            if (line.tx_active || frame_done) begin
                bit_cnt <= '0;  // host owns the line during a send
            end else if (shift_en) begin
                bit_cnt <= bit_cnt + 1'b1;
            end

            if (status_clear) begin
                has_data  <= 1'b0;
                parity_ok <= 1'b0;
            end else if (frame_done) begin
                has_data  <= 1'b1;
                rx_byte   <= frame_next[`PS2_DATA_W:1];
                // data plus parity bit must hold an odd number of ones
                parity_ok <= ^frame_next[`PS2_DATA_W+1:1];
            end
        end
    end

    assign line.rx_hold_clk = has_data;  // inhibit until the cpu clears
    assign rx_busy          = (bit_cnt != '0);

endmodule

//--- hw/ps2_transmitter.sv
`timescale 1ns/1ps
`include "ps2_params.svh"

module ps2_transmitter
    import ps2_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      tx_load,
    input  ps2_byte_t tx_byte,
    input  logic      status_clear,
    output logic      ack_ok,
    ps2_line_if.tx    line
);

    localparam int RTS_W = $clog2(`PS2_RTS_CYCLES);
    localparam logic [RTS_W-1:0] RTS_LAST = RTS_W'(`PS2_RTS_CYCLES - 1);
    localparam ps2_bit_cnt_t ACK_BIT = ps2_bit_cnt_t'(`PS2_FRAME_BITS - 1);

    typedef enum logic [1:0] {
        TX_IDLE,
        TX_RTS,
        TX_SEND
    } tx_state_t;

    tx_state_t        state;
    logic [RTS_W-1:0] rts_cnt;
    ps2_bit_cnt_t     bit_cnt;
    ps2_frame_t       shift;
    logic             rts_done;
    logic             send_fall;
    logic             ack_slot;

    assign rts_done  = (state == TX_RTS) && (rts_cnt == '0);
    assign send_fall = (state == TX_SEND) && line.clk_fall;  // falls during rts are our own
    assign ack_slot  = send_fall && (bit_cnt == ACK_BIT);

    // ==============================
    // sequence control
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= TX_IDLE;
            rts_cnt <= '0;
            bit_cnt <= '0;
        end else begin
            case (state)
                TX_IDLE: begin
                    if (tx_load) begin
                        state   <= TX_RTS;
                        rts_cnt <= RTS_LAST;
                    end
                end
                TX_RTS: begin
                    if (rts_done) begin
                        state   <= TX_SEND;
                        bit_cnt <= '0;
                    end else begin
                        rts_cnt <= rts_cnt - 1'b1;
                    end
                end
                TX_SEND: begin
                    if (send_fall) begin
                        bit_cnt <= bit_cnt + 1'b1;
                        if (ack_slot) begin
                            state <= TX_IDLE;  // ack sampled, transfer over
                        end
                    end
                end
                default: state <= TX_IDLE;
            endcase
        end
    end

    // frame is built at the end of rts, byte is stable by then
    always_ff @(posedge clk) begin
        if (rts_done) begin
            shift <= {1'b1, ~^tx_byte, tx_byte, 1'b0};  // stop, odd parity, data, start
        end else if (send_fall) begin
            shift <= {1'b1, shift[`PS2_FRAME_BITS-1:1]};
        end
    end

    // ==============================
    // acknowledge flag
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ack_ok <= 1'b0;
        end else if (ack_slot) begin
            ack_ok <= ~line.data_level;  // device pulls data low to ack
        end else if (status_clear) begin
            ack_ok <= 1'b0;
        end
    end

    assign line.tx_active   = (state != TX_IDLE);
    assign line.tx_clk_low  = (state == TX_RTS);
    // start bit is 0, so data goes low together with the clock
    assign line.tx_data_low = (state == TX_RTS) || ((state == TX_SEND) && !shift[0]);

endmodule

//--- hw/ps2_bus_port.sv
`timescale 1ns/1ps
`include "ps2_params.svh"

module ps2_bus_port
    import ps2_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      data_sel,
    input  logic      status_sel,
    input  logic      we,
    input  logic      oe,
    input  ps2_byte_t wr_data,
    input  ps2_byte_t rx_byte,
    input  logic      has_data,
    input  logic      parity_ok,
    input  logic      ack_ok,
    input  logic      rx_busy,
    input  logic      tx_busy,
    output ps2_byte_t rd_data,
    output logic      rdy,
    output logic      tx_load,
    output ps2_byte_t tx_byte,
    output logic      status_clear
);

    ps2_status_t status;

    // ==============================
    // write decode
    assign tx_load      = we & data_sel & ~tx_busy;  // dropped while sending
    assign status_clear = we & status_sel;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tx_byte <= '0;
        end else if (tx_load) begin
            tx_byte <= wr_data;  // held for the whole transfer
        end
    end

    // ==============================
    // read side
    always_comb begin
        status           = '0;
        status.has_data  = has_data;
        status.parity_ok = parity_ok;
        status.ack_ok    = ack_ok;
    end

    always_comb begin
        if (oe && data_sel) begin
            rd_data = rx_byte;
        end else if (oe && status_sel) begin
            rd_data = status;
        end else begin
            rd_data = {`PS2_DATA_W{1'b0}};
        end
    end

    assign rdy = ~(rx_busy | tx_busy);  // idle in both directions

endmodule

//--- hw/ps2_host.sv
`timescale 1ns/1ps

module ps2_host
    import ps2_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    // cpu side
    input  logic      data_sel,
    input  logic      status_sel,
    input  logic      we,
    input  logic      oe,
    input  ps2_byte_t wr_data,
    output ps2_byte_t rd_data,
    output logic      rdy,
    // ps/2 side, open-drain split into level and pull-down
    input  logic      ps2_clk_in,
    input  logic      ps2_data_in,
    output logic      ps2_clk_drive_low,
    output logic      ps2_data_drive_low
);

    ps2_byte_t rx_byte;
    ps2_byte_t tx_byte;
    logic      has_data;
    logic      parity_ok;
    logic      ack_ok;
    logic      rx_busy;
    logic      tx_load;
    logic      status_clear;

    ps2_line_if line_if ();

    ps2_line_sync line_sync_inst (
        .clk                (clk),
        .rst_n              (rst_n),
        .ps2_clk_in         (ps2_clk_in),
        .ps2_data_in        (ps2_data_in),
        .ps2_clk_drive_low  (ps2_clk_drive_low),
        .ps2_data_drive_low (ps2_data_drive_low),
        .line               (line_if.sync)
    );

    ps2_receiver receiver_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .status_clear (status_clear),
        .rx_byte      (rx_byte),
        .has_data     (has_data),
        .parity_ok    (parity_ok),
        .rx_busy      (rx_busy),
        .line         (line_if.rx)
    );

    ps2_transmitter transmitter_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .tx_load      (tx_load),
        .tx_byte      (tx_byte),
        .status_clear (status_clear),
        .ack_ok       (ack_ok),
        .line         (line_if.tx)
    );

    ps2_bus_port bus_port_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .data_sel     (data_sel),
        .status_sel   (status_sel),
        .we           (we),
        .oe           (oe),
        .wr_data      (wr_data),
        .rx_byte      (rx_byte),
        .has_data     (has_data),
        .parity_ok    (parity_ok),
        .ack_ok       (ack_ok),
        .rx_busy      (rx_busy),
        .tx_busy      (line_if.tx_active),
        .rd_data      (rd_data),
        .rdy          (rdy),
        .tx_load      (tx_load),
        .tx_byte      (tx_byte),
        .status_clear (status_clear)
    );

endmodule

//--- dv/tb_ps2_host.sv
`timescale 1ns/1ps
`include "ps2_params.svh"

module tb_ps2_host
    import ps2_pkg::*;
();

    localparam int DEV_HALF       = 20;  // device clock half-period in system cycles
    localparam int N_TRANSFERS    = 40;
    localparam int TIMEOUT_CYCLES = N_TRANSFERS * (`PS2_RTS_CYCLES + 12 * 40 + 100);

    logic      clk;
    logic      rst_n;
    logic      data_sel;
    logic      status_sel;
    logic      we;
    logic      oe;
    ps2_byte_t wr_data;
    ps2_byte_t rd_data;
    logic      rdy;
    logic      ps2_clk_in;
    logic      ps2_data_in;
    logic      ps2_clk_drive_low;
    logic      ps2_data_drive_low;
    logic      dev_clk;
    logic      dev_data;

    logic [15:0] lfsr;
    int          errors;
    int          cycles;
    int          n_rx;
    int          n_tx;

    // wired-and of device and host pull-downs
    assign ps2_clk_in  = dev_clk & ~ps2_clk_drive_low;
    assign ps2_data_in = dev_data & ~ps2_data_drive_low;

    ps2_host ps2_host_inst (
        .clk                (clk),
        .rst_n              (rst_n),
        .data_sel           (data_sel),
        .status_sel         (status_sel),
        .we                 (we),
        .oe                 (oe),
        .wr_data            (wr_data),
        .rd_data            (rd_data),
        .rdy                (rdy),
        .ps2_clk_in         (ps2_clk_in),
        .ps2_data_in        (ps2_data_in),
        .ps2_clk_drive_low  (ps2_clk_drive_low),
        .ps2_data_drive_low (ps2_data_drive_low)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles, the transfers never finished", cycles);
            $display("Test failed");
            $finish;
        end
    end

    // ==============================
    // helpers
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        lfsr_step = s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);  // galois with taps 16 14 13 11
    endfunction

    // odd parity bit is set when the byte holds an even number of ones
    function automatic logic odd_parity_bit(input ps2_byte_t b);
        int ones;
        ones = 0;
        for (int i = 0; i < `PS2_DATA_W; i++) begin
            ones += b[i];
        end
        odd_parity_bit = (ones % 2 == 0);
    endfunction

    task automatic draw_bits(input int n, output logic [7:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[6:0], lfsr[0]};
            lfsr = lfsr_step(lfsr);
        end
    endtask

    task automatic report_mismatch(input string name, input logic [7:0] expected,
                                   input logic [7:0] actual);
        errors++;
        $display("FAILED %s: expected 0x%02h, actual 0x%02h", name, expected, actual);
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) @(negedge clk);
    endtask

    task automatic bus_write(input logic to_status, input ps2_byte_t value);
        @(negedge clk);
        data_sel   = ~to_status;
        status_sel = to_status;
        we         = 1'b1;
        wr_data    = value;
        @(negedge clk);
        data_sel   = 1'b0;
        status_sel = 1'b0;
        we         = 1'b0;
    endtask

    task automatic bus_read(input logic from_status, output ps2_byte_t value);
        @(negedge clk);
        data_sel   = ~from_status;
        status_sel = from_status;
        oe         = 1'b1;
        #1;
        value = rd_data;  // combinational read
        @(negedge clk);
        data_sel   = 1'b0;
        status_sel = 1'b0;
        oe         = 1'b0;
    endtask

    // device to host frame with data changing while the clock is high
    task automatic device_send(input ps2_byte_t value, input logic bad_parity,
                               output logic mid_rdy);
        logic [10:0] frame;
        frame = {1'b1, odd_parity_bit(value) ^ bad_parity, value, 1'b0};
        for (int i = 0; i < `PS2_FRAME_BITS; i++) begin
            dev_data = frame[i];
            wait_cycles(DEV_HALF / 2);
            dev_clk = 1'b0;
            wait_cycles(DEV_HALF);
            if (i == 5) begin
                mid_rdy = rdy;
            end
            dev_clk = 1'b1;
            wait_cycles(DEV_HALF / 2);
        end
        dev_data = 1'b1;
    endtask

    // host to device frame sampled just before each fall
    task automatic device_capture(input logic ack, output logic [10:0] bits,
                                  output logic mid_rdy);
        for (int i = 0; i < `PS2_FRAME_BITS; i++) begin
            wait_cycles(DEV_HALF / 2);
            bits[i] = ps2_data_in;
            if (i == `PS2_FRAME_BITS - 1) begin
                dev_data = ~ack;  // ack goes out in the last slot
                wait_cycles(2);
            end
            dev_clk = 1'b0;
            wait_cycles(DEV_HALF);
            if (i == 5) begin
                mid_rdy = rdy;
            end
            dev_clk = 1'b1;
        end
        dev_data = 1'b1;
    endtask

    // ==============================
    // main sequence
    initial begin
        ps2_byte_t   value;
        ps2_byte_t   got;
        logic [7:0]  pick;
        logic [10:0] bits;
        logic        bad;
        logic        ack;
        logic        mid_rdy;
        int          rts_len;

        lfsr       = 16'd35313;
        errors     = 0;
        cycles     = 0;
        n_rx       = 0;
        n_tx       = 0;
        rst_n      = 1'b0;
        data_sel   = 1'b0;
        status_sel = 1'b0;
        we         = 1'b0;
        oe         = 1'b0;
        wr_data    = '0;
        dev_clk    = 1'b1;
        dev_data   = 1'b1;
        wait_cycles(16);
        rst_n = 1'b1;
        wait_cycles(2);

        if (ps2_clk_drive_low !== 1'b0)
            report_mismatch("reset clk drive", 8'h00, 8'(ps2_clk_drive_low));
        if (ps2_data_drive_low !== 1'b0)
            report_mismatch("reset data drive", 8'h00, 8'(ps2_data_drive_low));
        if (rdy !== 1'b1) report_mismatch("reset rdy", 8'h01, 8'(rdy));
        bus_read(1'b1, got);
        if (got !== 8'h00) report_mismatch("reset status", 8'h00, got);

        for (int t = 0; t < N_TRANSFERS; t++) begin
            draw_bits(1, pick);
            draw_bits(8, value);
            if (pick[0]) begin
                // receive path
                draw_bits(2, pick);
                bad = (pick[1:0] == 2'b00);  // one frame in four
                device_send(value, bad, mid_rdy);
                if (mid_rdy !== 1'b0) report_mismatch("rx rdy mid frame", 8'h00, 8'(mid_rdy));
                if (ps2_clk_drive_low !== 1'b1)
                    report_mismatch("rx inhibit", 8'h01, 8'(ps2_clk_drive_low));
                if (rdy !== 1'b1) report_mismatch("rx rdy idle", 8'h01, 8'(rdy));
                bus_read(1'b1, got);
                if (got !== {6'b0, ~bad, 1'b1})
                    report_mismatch("rx status", {6'b0, ~bad, 1'b1}, got);
                bus_read(1'b0, got);
                if (got !== value) report_mismatch("rx data", value, got);
                bus_write(1'b1, 8'h00);
                wait_cycles(1);
                if (ps2_clk_drive_low !== 1'b0)
                    report_mismatch("rx release", 8'h00, 8'(ps2_clk_drive_low));
                bus_read(1'b1, got);
                if (got !== 8'h00) report_mismatch("rx status cleared", 8'h00, got);
                n_rx++;
            end else begin
                // send path
                draw_bits(1, pick);
                ack = pick[0];
                bus_write(1'b0, value);
                if (rdy !== 1'b0) report_mismatch("tx rdy after write", 8'h00, 8'(rdy));
                while (!ps2_clk_drive_low) @(negedge clk);
                rts_len = 0;
                while (ps2_clk_drive_low) begin
                    rts_len++;
                    @(negedge clk);
                end
                if (rts_len < `PS2_RTS_CYCLES) begin
                    errors++;
                    $display("FAILED tx rts hold: expected at least %0d cycles, actual %0d",
                             `PS2_RTS_CYCLES, rts_len);
                end
                device_capture(ack, bits, mid_rdy);
                if (mid_rdy !== 1'b0) report_mismatch("tx rdy mid frame", 8'h00, 8'(mid_rdy));
                if (bits[0] !== 1'b0) report_mismatch("tx start bit", 8'h00, 8'(bits[0]));
                if (bits[8:1] !== value) report_mismatch("tx data bits", value, bits[8:1]);
                if (bits[9] !== odd_parity_bit(value))
                    report_mismatch("tx parity", 8'(odd_parity_bit(value)), 8'(bits[9]));
                if (bits[10] !== 1'b1) report_mismatch("tx stop bit", 8'h01, 8'(bits[10]));
                while (!rdy) @(negedge clk);
                bus_read(1'b1, got);
                if (got !== {5'b0, ack, 2'b0})
                    report_mismatch("tx ack status", {5'b0, ack, 2'b0}, got);
                bus_write(1'b1, 8'h00);
                n_tx++;
            end
            wait_cycles(DEV_HALF);
        end

        $display("errors: %0d, receives: %0d, sends: %0d", errors, n_rx, n_tx);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- all.f
+incdir+hw
hw/ps2_pkg.sv
hw/ps2_line_if.sv
hw/ps2_line_sync.sv
hw/ps2_receiver.sv
hw/ps2_transmitter.sv
hw/ps2_bus_port.sv
hw/ps2_host.sv
dv/tb_ps2_host.sv

//--- run.sh
#!/bin/sh
# build the ps/2 host testbench with verilator, run it, check the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing -j 0 -f all.f --top-module tb_ps2_host -o sim_tb \
    && ./obj_dir/sim_tb > sim.log 2>&1 \
    || { echo "build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "^Test passed$" sim.log \
    && { echo "simulation ok"; exit 0; } \
    || { echo "simulation reported errors"; exit 1; }
